// ==== Makefile ====
TOP = tb_lsu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_lsu_top.sv ====
`timescale 1ns/1ns

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int mem_words    = 256;
    localparam int byte_bits    = $clog2(mem_words * 4);
    localparam int window_words = 16;
    localparam int ready_limit  = 50;
    localparam int drain_limit  = 400;

    typedef logic [byte_bits-1:0] byte_index_t;

    typedef struct packed {
        logic        fault;
        logic [31:0] data;
        logic [4:0]  rd;
        logic        is_load;
    } resp_t;

    typedef struct packed {
        resp_t       resp;
        logic [31:0] accept_cycle;
    } pending_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    instr_t      req_instr;
    logic [31:0] req_rs1;
    logic [31:0] req_rs2;
    logic        resp_valid;
    logic        resp_ready = 1'b1;
    logic [31:0] resp_data;
    logic [4:0]  resp_rd;
    logic        resp_fault;
    logic        resp_is_load;

    logic [7:0]  shadow [mem_words * 4];
    pending_t    pending [$];
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_errors_start;
    bit          timed_out;
    bit          backpressure;
    bit          was_valid;
    bit          held;
    resp_t       held_resp;
    resp_t       actual;

    lsu_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_instr    (req_instr),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .resp_rd      (resp_rd),
        .resp_fault   (resp_fault),
        .resp_is_load (resp_is_load)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, error_count - test_errors_start);
        test_errors_start = error_count;
    endtask

    function automatic instr_t make_load(input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [11:0] imm);
        instr_t ins;
        ins               = '0;
        ins.i_view.opcode = opcode_load;
        ins.i_view.funct3 = funct3;
        ins.i_view.rd     = rd;
        ins.i_view.rs1    = 5'd1;
        ins.i_view.imm    = imm;
        return ins;
    endfunction

    function automatic instr_t make_store(input logic [2:0] funct3, input logic [11:0] imm);
        instr_t ins;
        ins               = '0;
        ins.s_view.opcode = opcode_store;
        ins.s_view.funct3 = funct3;
        ins.s_view.rs1    = 5'd1;
        ins.s_view.rs2    = 5'd2;
        ins.s_view.imm_hi = imm[11:5];
        ins.s_view.imm_lo = imm[4:0];
        return ins;
    endfunction

    // Expected response, stores also update the shadow bytes
    function automatic resp_t reference_access(input instr_t ins, input logic [31:0] rs1,
                                               input logic [31:0] rs2);
        resp_t       result;
        logic        is_load;
        logic        is_store;
        logic        legal;
        logic        signed_load;
        logic [31:0] addr;
        logic [31:0] raw;
        int          size;
        byte_index_t idx;

        is_load  = (ins.i_view.opcode == opcode_load);
        is_store = (ins.s_view.opcode == opcode_store);
        if (is_store)
            addr = rs1 + 32'($signed({ins.s_view.imm_hi, ins.s_view.imm_lo}));
        else
            addr = rs1 + 32'($signed(ins.i_view.imm));
        legal       = is_load || is_store;
        signed_load = 1'b0;
        size        = 4;
        case (ins.i_view.funct3)
            funct3_byte:
            begin
                size        = 1;
                signed_load = 1'b1;
            end
            funct3_half:
            begin
                size        = 2;
                signed_load = 1'b1;
            end
            funct3_word:
            begin
                size = 4;
            end
            funct3_byte_u:
            begin
                size  = 1;
                legal = legal && is_load;
            end
            funct3_half_u:
            begin
                size  = 2;
                legal = legal && is_load;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
        result.fault = !legal || (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'd0)
                    || (addr >= 32'(mem_words * 4));
        result.is_load = is_load;
        result.rd      = is_load ? ins.i_view.rd : 5'd0;
        result.data    = 32'd0;
        if (!result.fault)
        begin
            raw = 32'd0;
            for (int i = 0; i < size; i++)
            begin
                idx = byte_index_t'(addr + 32'(i));
                if (is_store)
                    shadow[idx] = 8'(rs2 >> (8 * i));
                else
                    raw = raw | (32'(shadow[idx]) << (8 * i));
            end
            if (signed_load && size == 1)
                raw = 32'($signed(raw[7:0]));
            else if (signed_load && size == 2)
                raw = 32'($signed(raw[15:0]));
            if (is_load)
                result.data = raw;
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    // Called and returns on a falling edge
    task automatic send_request(input instr_t ins, input logic [31:0] rs1,
                                input logic [31:0] rs2);
        pending_t entry;
        int       waited;
        if (timed_out)
            return;
        req_valid = 1'b1;
        req_instr = ins;
        req_rs1   = rs1;
        req_rs2   = rs2;
        waited    = 0;
        while (!req_ready && waited < ready_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready)
        begin
            $display("timeout at %0t: req_ready never rose for a request", $time);
            error_count++;
            timed_out = 1'b1;
            req_valid = 1'b0;
            return;
        end
        entry.resp         = reference_access(ins, rs1, rs2);
        entry.accept_cycle = 32'(cycle_count + 1);
        pending.push_back(entry);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic random_access();
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] off;
        logic        store;
        store = (($urandom % 2) == 1);
        addr  = $urandom % (window_words * 4);
        if (store)
        begin
            case ($urandom % 3)
                0:       funct3 = funct3_byte;
                1:       funct3 = funct3_half;
                default: funct3 = funct3_word;
            endcase
        end
        else
        begin
            case ($urandom % 5)
                0:       funct3 = funct3_byte;
                1:       funct3 = funct3_half;
                2:       funct3 = funct3_word;
                3:       funct3 = funct3_byte_u;
                default: funct3 = funct3_half_u;
            endcase
        end
        // Mostly aligned, now and then a misaligned one
        if (($urandom % 8) != 0)
        begin
            if (funct3[1:0] == 2'b01)
                addr[0] = 1'b0;
            if (funct3 == funct3_word)
                addr[1:0] = 2'b00;
        end
        off = $urandom % 32;
        if (store)
            send_request(make_store(funct3, 12'(32'd0 - off)), addr + off, $urandom);
        else
            send_request(make_load(funct3, 5'($urandom), 12'(32'd0 - off)), addr + off, 32'd0);
        repeat ($urandom % 4) @(negedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        if (timed_out)
            return;
        waited = 0;
        while ((pending.size() != 0 || !req_ready) && waited < drain_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending.size() != 0 || !req_ready)
        begin
            $display("timeout at %0t: outstanding responses never arrived", $time);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic set_backpressure(input bit on);
        @(posedge clk);
        backpressure = on;
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Response compare
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        actual = {resp_fault, resp_data, resp_rd, resp_is_load};
        if (reset)
        begin
            was_valid = 1'b0;
            held      = 1'b0;
        end
        else
        begin
            if (held)
            begin
                check_value(64'(resp_valid), 64'(1), "resp_valid under back-pressure");
                check_value(64'(actual), 64'(held_resp), "payload under back-pressure");
            end
            if (resp_valid)
                check_value(64'(req_ready), 64'(0), "req_ready with a response pending");
            if (resp_valid && !was_valid && pending.size() != 0)
                check_value(64'(32'(cycle_count) - pending[0].accept_cycle), 64'(2),
                            "cycles from acceptance to resp_valid");
            resp_ready = backpressure ? (($urandom % 3) == 0) : 1'b1;
            if (resp_valid && resp_ready)
            begin
                if (pending.size() == 0)
                begin
                    $display("error at %0t: response arrived with no request outstanding",
                             $time);
                    error_count++;
                end
                else
                begin
                    check_value(64'(resp_fault), 64'(pending[0].resp.fault), "resp_fault");
                    check_value(64'(resp_data), 64'(pending[0].resp.data), "resp_data");
                    check_value(64'(resp_rd), 64'(pending[0].resp.rd), "resp_rd");
                    check_value(64'(resp_is_load), 64'(pending[0].resp.is_load),
                                "resp_is_load");
                    void'(pending.pop_front());
                end
            end
            was_valid = resp_valid;
            held      = resp_valid && !resp_ready;
            held_resp = actual;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        void'($urandom(29732));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_instr = '0;
        req_rs1   = 32'd0;
        req_rs2   = 32'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value(64'(req_ready), 64'(1), "req_ready after reset");
        check_value(64'(resp_valid), 64'(0), "resp_valid after reset");
        // Fill the window so later loads see known data
        for (int w = 0; w < window_words; w++)
            send_request(make_store(funct3_word, 12'd0), 32'(w * 4), $urandom);
        for (int w = 0; w < window_words; w++)
            send_request(make_load(funct3_word, 5'(w + 1), 12'd0), 32'(w * 4), 32'd0);
        wait_drain();
        report_test("word store and load");

        // Word read back after every partial store
        for (int off = 0; off < 4; off++)
        begin
            send_request(make_store(funct3_byte, 12'(off)), 32'd8,
                         {24'($urandom), off[0], 7'($urandom)});
            send_request(make_load(funct3_word, 5'd2, 12'd0), 32'd8, 32'd0);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            send_request(make_store(funct3_half, 12'(off)), 32'd12,
                         {16'($urandom), off[1], 15'($urandom)});
            send_request(make_load(funct3_word, 5'd3, 12'd0), 32'd12, 32'd0);
        end
        for (int base = 8; base <= 12; base += 4)
        begin
            for (int off = 0; off < 4; off++)
            begin
                send_request(make_load(funct3_byte, 5'd4, 12'(off)), 32'(base), 32'd0);
                send_request(make_load(funct3_byte_u, 5'd5, 12'(off)), 32'(base), 32'd0);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                send_request(make_load(funct3_half, 5'd6, 12'(off)), 32'(base), 32'd0);
                send_request(make_load(funct3_half_u, 5'd7, 12'(off)), 32'(base), 32'd0);
            end
        end
        wait_drain();
        report_test("byte and half lanes");

        for (int off = 1; off < 4; off++)
        begin
            send_request(make_load(funct3_word, 5'd8, 12'(off)), 32'd16, 32'd0);
            send_request(make_store(funct3_word, 12'(off)), 32'd16, $urandom);
            if (off != 2)
            begin
                send_request(make_load(funct3_half, 5'd9, 12'(off)), 32'd16, 32'd0);
                send_request(make_store(funct3_half, 12'(off)), 32'd16, $urandom);
            end
        end
        send_request(make_load(funct3_word, 5'd10, 12'd0), 32'd16, 32'd0);
        send_request(make_load(funct3_word, 5'd11, 12'd0), 32'd20, 32'd0);
        wait_drain();
        report_test("misaligned faults");

        send_request(make_load(funct3_word, 5'd12, 12'd0), 32'(mem_words * 4), 32'd0);
        send_request(make_store(funct3_byte, 12'hffc), 32'(mem_words * 4 + 4), $urandom);
        send_request(make_load(funct3_byte_u, 5'd13, 12'hffc), 32'd0, 32'd0);
        send_request(make_load(funct3_word, 5'd14, 12'hff8), 32'd16, 32'd0);
        send_request(make_store(funct3_half, 12'hffe), 32'd30, $urandom);
        send_request(make_load(funct3_word, 5'd15, 12'd0), 32'd4, 32'd0);
        send_request(make_load(3'b011, 5'd16, 12'd0), 32'd4, 32'd0);
        send_request(make_load(3'b110, 5'd17, 12'd0), 32'd4, 32'd0);
        send_request(make_load(3'b111, 5'd18, 12'd0), 32'd4, 32'd0);
        send_request(make_store(funct3_byte_u, 12'd0), 32'd0, $urandom);
        send_request(make_store(funct3_half_u, 12'd0), 32'd0, $urandom);
        send_request(make_load(funct3_word, 5'd19, 12'd0), 32'd0, 32'd0);
        send_request(make_load(funct3_word, 5'd20, 12'd0), 32'd28, 32'd0);
        wait_drain();
        report_test("range and encoding faults");

        set_backpressure(1'b1);
        repeat (40) random_access();
        wait_drain();
        set_backpressure(1'b0);
        report_test("back-pressure");

        repeat (300) random_access();
        wait_drain();
        report_test("random mix");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== source/lsu_address_gen.sv ====
`timescale 1ns/1ns

module lsu_address_gen #(
    parameter int MEM_WORDS = 256
) (
    input  lsu_pkg::instr_t               cur_instr,
    input  logic [31:0]                   cur_rs1,
    output logic [$clog2(MEM_WORDS)-1:0]  word_index,
    output logic [1:0]                    byte_offset,
    output lsu_pkg::width_t               access_width,
    output logic                          load_signed,
    output logic                          is_load,
    output logic                          addr_fault
);
    import lsu_pkg::*;

    localparam int          index_bits = $clog2(MEM_WORDS);
    localparam logic [32:0] mem_bytes  = 33'(MEM_WORDS) * 33'd4;

    logic        is_store;
    logic [31:0] imm_ext;
    logic [31:0] eff_addr;
    logic        funct3_ok;
    logic        misaligned;
    logic        out_of_range;

    assign is_load  = (cur_instr.i_view.opcode == opcode_load);
    assign is_store = (cur_instr.s_view.opcode == opcode_store);

    // Store immediate is split around rs2
    assign imm_ext = is_store
        ? {{20{cur_instr.s_view.imm_hi[6]}}, cur_instr.s_view.imm_hi, cur_instr.s_view.imm_lo}
        : {{20{cur_instr.i_view.imm[11]}}, cur_instr.i_view.imm};

    assign eff_addr    = cur_rs1 + imm_ext;
    assign byte_offset = eff_addr[1:0];
    assign word_index  = eff_addr[index_bits+1:2];

    always_comb
    begin
        access_width = width_word;
        load_signed  = 1'b0;
        funct3_ok    = 1'b1;
        case (cur_instr.i_view.funct3)
            funct3_byte:
            begin
                access_width = width_byte;
                load_signed  = 1'b1;
            end
            funct3_half:
            begin
                access_width = width_half;
                load_signed  = 1'b1;
            end
            funct3_word:
            begin
                access_width = width_word;
            end
            // Unsigned forms exist for loads only
            funct3_byte_u:
            begin
                access_width = width_byte;
                funct3_ok    = is_load;
            end
            funct3_half_u:
            begin
                access_width = width_half;
                funct3_ok    = is_load;
            end
            default:
            begin
                funct3_ok = 1'b0;
            end
        endcase
    end

    assign misaligned = ((access_width == width_half) && byte_offset[0])
                     || ((access_width == width_word) && (byte_offset != 2'd0));

    assign out_of_range = ({1'b0, eff_addr} >= mem_bytes);

    assign addr_fault = !(is_load || is_store) || !funct3_ok || misaligned || out_of_range;

endmodule

// ==== source/lsu_control.sv ====
`timescale 1ns/1ns

module lsu_control (
    input  logic             clk,
    input  logic             reset,

    input  logic             req_valid,
    output logic             req_ready,
    input  lsu_pkg::instr_t  req_instr,
    input  logic [31:0]      req_rs1,
    input  logic [31:0]      req_rs2,

    output logic             resp_valid,
    input  logic             resp_ready,
    output logic [31:0]      resp_data,
    output logic [4:0]       resp_rd,
    output logic             resp_fault,
    output logic             resp_is_load,

    output lsu_pkg::instr_t  cur_instr,
    output logic [31:0]      cur_rs1,
    output logic [31:0]      cur_rs2,
    input  logic             addr_fault,
    input  logic [31:0]      load_value,
    output logic             mem_enable,
    output logic             mem_write
);
    import lsu_pkg::*;

    localparam logic [1:0] state_idle    = 2'd0;
    localparam logic [1:0] state_access  = 2'd1;
    localparam logic [1:0] state_respond = 2'd2;

    logic [1:0] state;
    logic       accept;
    logic       cur_is_load;
    logic       cur_is_store;

    assign req_ready = (state == state_idle);
    assign accept    = req_valid && req_ready;

    assign cur_is_load  = (cur_instr.i_view.opcode == opcode_load);
    assign cur_is_store = (cur_instr.s_view.opcode == opcode_store);

    ////////////////////////////////////////
    // Request capture
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_instr <= req_instr;
            cur_rs1   <= req_rs1;
            cur_rs2   <= req_rs2;
        end
    end

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= state_idle;
        end
        else
        begin
            case (state)
                state_idle:
                begin
                    if (accept)
                        state <= state_access;
                end
                state_access:
                begin
                    state <= state_respond;
                end
                state_respond:
                begin
                    if (resp_valid && resp_ready)
                        state <= state_idle;
                end
                default:
                begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // Faulted requests never touch memory
    assign mem_enable = (state == state_access) && !addr_fault;
    assign mem_write  = mem_enable && cur_is_store;

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            resp_valid <= 1'b0;
        else if (state == state_respond && !resp_valid)
            resp_valid <= 1'b1;
        else if (resp_valid && resp_ready)
            resp_valid <= 1'b0;
    end

    // Loaded once, then held through back-pressure
    always_ff @(posedge clk)
    begin
        if (state == state_respond && !resp_valid)
        begin
            resp_fault   <= addr_fault;
            resp_is_load <= cur_is_load;
            resp_rd      <= cur_is_load ? cur_instr.i_view.rd : rd_none;
            if (addr_fault || !cur_is_load)
                resp_data <= resp_data_none;
            else
                resp_data <= load_value;
        end
    end

endmodule

// ==== source/lsu_data_memory.sv ====
`timescale 1ns/1ns

module lsu_data_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          mem_enable,
    input  logic                          mem_write,
    input  logic [$clog2(MEM_WORDS)-1:0]  word_index,
    input  logic [3:0]                    byte_mask,
    input  logic [31:0]                   mem_wdata,
    output logic [31:0]                   mem_rdata
);

    logic [31:0] mem [MEM_WORDS];

    // Write side, masked bytes only
    always_ff @(posedge clk)
    begin
        if (mem_enable && mem_write)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byte_mask[i])
                begin
                    mem[word_index][8*i +: 8] <= mem_wdata[8*i +: 8];
                end
            end
        end
    end

    // Read data holds until the next enabled read
    always_ff @(posedge clk)
    begin
        if (mem_enable && !mem_write)
        begin
            mem_rdata <= mem[word_index];
        end
    end

endmodule

// ==== source/lsu_lane_align.sv ====
`timescale 1ns/1ns

module lsu_lane_align (
    input  lsu_pkg::width_t  access_width,
    input  logic             load_signed,
    input  logic [1:0]       byte_offset,
    input  logic [31:0]      cur_rs2,
    input  logic [31:0]      mem_rdata,
    output logic [3:0]       byte_mask,
    output logic [31:0]      mem_wdata,
    output logic [31:0]      load_value
);
    import lsu_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    ////////////////////////////////////////
    // Store side
    ////////////////////////////////////////

    // Mask bit i enables byte lane i, little-endian
    always_comb
    begin
        case (access_width)
            width_byte:
            begin
                case (byte_offset)
                    2'd0:    byte_mask = 4'b0001;
                    2'd1:    byte_mask = 4'b0010;
                    2'd2:    byte_mask = 4'b0100;
                    default: byte_mask = 4'b1000;
                endcase
            end
            width_half:
            begin
                byte_mask = byte_offset[1] ? 4'b1100 : 4'b0011;
            end
            width_word:
            begin
                byte_mask = 4'b1111;
            end
            default:
            begin
                byte_mask = 4'b0000;
            end
        endcase
    end

    // Replicate into every lane, the mask picks the live ones
    always_comb
    begin
        case (access_width)
            width_byte: mem_wdata = {4{cur_rs2[7:0]}};
            width_half: mem_wdata = {2{cur_rs2[15:0]}};
            default:    mem_wdata = cur_rs2;
        endcase
    end

    ////////////////////////////////////////
    // Load side
    ////////////////////////////////////////

    always_comb
    begin
        case (byte_offset)
            2'd0:    load_byte = mem_rdata[7:0];
            2'd1:    load_byte = mem_rdata[15:8];
            2'd2:    load_byte = mem_rdata[23:16];
            default: load_byte = mem_rdata[31:24];
        endcase
    end

    // Odd half offsets fault upstream
    assign load_half = byte_offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb
    begin
        case (access_width)
            width_byte:
            begin
                if (load_signed)
                    load_value = {{24{load_byte[7]}}, load_byte};
                else
                    load_value = {24'd0, load_byte};
            end
            width_half:
            begin
                if (load_signed)
                    load_value = {{16{load_half[15]}}, load_half};
                else
                    load_value = {16'd0, load_half};
            end
            default:
            begin
                load_value = mem_rdata;
            end
        endcase
    end

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    ////////////////////////////////////////
    // Access size and signedness
    ////////////////////////////////////////

    localparam logic [2:0] funct3_byte   = 3'b000;
    localparam logic [2:0] funct3_half   = 3'b001;
    localparam logic [2:0] funct3_word   = 3'b010;
    localparam logic [2:0] funct3_byte_u = 3'b100;
    localparam logic [2:0] funct3_half_u = 3'b101;

    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } width_t;

    ////////////////////////////////////////
    // Response codes
    ////////////////////////////////////////

    // Stores report no destination register
    localparam logic [4:0]  rd_none        = 5'd0;
    // Faults and stores return no data
    localparam logic [31:0] resp_data_none = 32'd0;

    ////////////////////////////////////////
    // Instruction word, load and store views
    ////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_view;
    } instr_t;

endpackage

// ==== source/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             req_valid,
    output logic             req_ready,
    input  lsu_pkg::instr_t  req_instr,
    input  logic [31:0]      req_rs1,
    input  logic [31:0]      req_rs2,

    output logic             resp_valid,
    input  logic             resp_ready,
    output logic [31:0]      resp_data,
    output logic [4:0]       resp_rd,
    output logic             resp_fault,
    output logic             resp_is_load
);
    import lsu_pkg::*;

    instr_t                         cur_instr;
    logic [31:0]                    cur_rs1;
    logic [31:0]                    cur_rs2;
    logic [$clog2(MEM_WORDS)-1:0]   word_index;
    logic [1:0]                     byte_offset;
    width_t                         access_width;
    logic                           load_signed;
    logic                           addr_fault;
    logic [3:0]                     byte_mask;
    logic [31:0]                    mem_wdata;
    logic [31:0]                    mem_rdata;
    logic [31:0]                    load_value;
    logic                           mem_enable;
    logic                           mem_write;

    lsu_control control0 (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_instr    (req_instr),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .resp_rd      (resp_rd),
        .resp_fault   (resp_fault),
        .resp_is_load (resp_is_load),
        .cur_instr    (cur_instr),
        .cur_rs1      (cur_rs1),
        .cur_rs2      (cur_rs2),
        .addr_fault   (addr_fault),
        .load_value   (load_value),
        .mem_enable   (mem_enable),
        .mem_write    (mem_write)
    );

    // Control decodes the opcode itself, is_load stays local
    lsu_address_gen #(
        .MEM_WORDS (MEM_WORDS)
    ) address_gen0 (
        .cur_instr    (cur_instr),
        .cur_rs1      (cur_rs1),
        .word_index   (word_index),
        .byte_offset  (byte_offset),
        .access_width (access_width),
        .load_signed  (load_signed),
        .is_load      (),
        .addr_fault   (addr_fault)
    );

    lsu_lane_align lane_align0 (
        .access_width (access_width),
        .load_signed  (load_signed),
        .byte_offset  (byte_offset),
        .cur_rs2      (cur_rs2),
        .mem_rdata    (mem_rdata),
        .byte_mask    (byte_mask),
        .mem_wdata    (mem_wdata),
        .load_value   (load_value)
    );

    lsu_data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) data_memory0 (
        .clk          (clk),
        .mem_enable   (mem_enable),
        .mem_write    (mem_write),
        .word_index   (word_index),
        .byte_mask    (byte_mask),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata)
    );

endmodule

// ==== vlog.f ====
source/lsu_pkg.sv
source/lsu_address_gen.sv
source/lsu_lane_align.sv
source/lsu_data_memory.sv
source/lsu_control.sv
source/lsu_top.sv
dv/tb_lsu_top.sv
